/* vision_pkg.sv */
package vision_pkg;

    typedef logic [10:0] coord_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        rgb_t pix;
        logic sop;
        logic eop;
    } beat_t;

    // Order is also the edge priority in the overlay
    typedef enum logic [2:0] {
        CLR_NONE   = 3'd0,
        CLR_RED    = 3'd1,
        CLR_BLUE   = 3'd2,
        CLR_GREEN  = 3'd3,
        CLR_YELLOW = 3'd4
    } colour_e;

    typedef struct packed {
        beat_t   beat;
        logic    video;
        coord_t  x;
        coord_t  y;
        colour_e colour;
    } tagged_t;

    typedef struct packed {
        coord_t left;
        coord_t right;
        coord_t top;
        coord_t bottom;
    } box_t;

    typedef box_t [4:1] box_set_t;   // Indexed by colour_e

    localparam logic [7:0] CLASS_HI = 8'hC0;
    localparam logic [7:0] CLASS_LO = 8'h40;

    localparam rgb_t COL_RED    = 24'hFF0000;
    localparam rgb_t COL_BLUE   = 24'hCCFFFF;
    localparam rgb_t COL_GREEN  = 24'h00FF00;
    localparam rgb_t COL_YELLOW = 24'hFFFF00;

    // Display colour of a class
    function automatic rgb_t class_rgb(colour_e c);
        case (c)
            CLR_RED:    return COL_RED;
            CLR_BLUE:   return COL_BLUE;
            CLR_GREEN:  return COL_GREEN;
            CLR_YELLOW: return COL_YELLOW;
            default:    return '0;
        endcase
    endfunction

endpackage

/* bus_pkg.sv */
package bus_pkg;

    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    // Register map
    localparam logic [3:0] ADDR_STATUS = 4'h0;
    localparam logic [3:0] ADDR_MSG    = 4'h4;
    localparam logic [3:0] ADDR_ID     = 4'h8;

    localparam logic [31:0] LOCATOR_ID   = 32'h1234EEE2;
    localparam logic [31:0] MSG_START_ID = {8'h00, "RBB"};  // Report header word

    localparam int MSG_WORDS  = 9;
    localparam int FIFO_DEPTH = 256;

endpackage

/* stream_reg.sv */
`timescale 1ns/1ps

module stream_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    // Slot free, or its beat leaves this cycle
    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

/* pixel_tagger.sv */
`timescale 1ns/1ps

module pixel_tagger import vision_pkg::*; #(
    parameter int IMAGE_W = 640,
    parameter int IMAGE_H = 480
) (
    input  logic    clk,
    input  logic    reset_n,
    input  beat_t   in_beat,
    input  logic    in_valid,
    output logic    in_ready,
    output tagged_t out_tag,
    output logic    out_valid,
    input  logic    out_ready
);

    logic    video_q;
    coord_t  x_cnt;
    coord_t  y_cnt;
    logic    take;
    logic    is_video;
    rgb_t    p;
    colour_e colour;

    assign in_ready = ~out_valid | out_ready;
    assign take     = in_valid & in_ready;
    assign p        = in_beat.pix;
    assign is_video = in_beat.sop ? (p.b[3:0] == 4'h0) : video_q;  // Descriptor on sop

    ////////////////////////////////
    // Colour classes in priority order
    always_comb begin
        colour = CLR_NONE;
        if (is_video && !in_beat.sop) begin
            if (p.r >= CLASS_HI && p.g < CLASS_LO && p.b < CLASS_LO) begin
                colour = CLR_RED;
            end else if (p.b >= CLASS_HI && p.r < CLASS_LO && p.g < CLASS_LO) begin
                colour = CLR_BLUE;
            end else if (p.g >= CLASS_HI && p.r < CLASS_LO && p.b < CLASS_LO) begin
                colour = CLR_GREEN;
            end else if (p.r >= CLASS_HI && p.g >= CLASS_HI && p.b < CLASS_LO) begin
                colour = CLR_YELLOW;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
            video_q   <= 1'b0;
            x_cnt     <= '0;
            y_cnt     <= '0;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;
            end
            if (take) begin
                if (in_beat.sop) begin
                    video_q <= is_video;
                    x_cnt   <= '0;
                    y_cnt   <= '0;
                end else if (x_cnt == coord_t'(IMAGE_W - 1)) begin
                    x_cnt <= '0;
                    y_cnt <= (y_cnt == coord_t'(IMAGE_H - 1)) ? '0 : y_cnt + 1'b1;
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_tag.beat   <= in_beat;
            out_tag.video  <= is_video;
            out_tag.x      <= in_beat.sop ? '0 : x_cnt;
            out_tag.y      <= in_beat.sop ? '0 : y_cnt;
            out_tag.colour <= colour;
        end
    end

endmodule

/* box_tracker.sv */
`timescale 1ns/1ps

module box_tracker import vision_pkg::*; #(
    parameter int IMAGE_W      = 640,
    parameter int IMAGE_H      = 480,
    parameter int MSG_INTERVAL = 30
) (
    input  logic     clk,
    input  logic     reset_n,
    input  tagged_t  tag,
    input  logic     tag_fire,
    output box_set_t boxes,
    output logic     report_start
);

    localparam int CNT_W = $clog2(MSG_INTERVAL + 1);

    box_set_t         run_q;
    box_set_t         run_d;
    logic [CNT_W-1:0] frame_cnt;
    logic             frame_end;

    assign frame_end = tag_fire & tag.video & tag.beat.eop;

    ////////////////////////////////
    // Running boxes
    always_comb begin
        run_d = run_q;
        if (tag.beat.sop) begin
            for (int c = 1; c <= 4; c++) begin
                run_d[c].left   = coord_t'(IMAGE_W - 1);
                run_d[c].right  = '0;
                run_d[c].top    = coord_t'(IMAGE_H - 1);
                run_d[c].bottom = '0;
            end
        end else if (tag.video && tag.colour != CLR_NONE) begin
            if (tag.x < run_q[tag.colour].left) begin
                run_d[tag.colour].left = tag.x;
            end
            if (tag.x > run_q[tag.colour].right) begin
                run_d[tag.colour].right = tag.x;
            end
            if (tag.y < run_q[tag.colour].top) begin
                run_d[tag.colour].top = tag.y;
            end
            if (tag.y > run_q[tag.colour].bottom) begin
                run_d[tag.colour].bottom = tag.y;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_fire) begin
            run_q <= run_d;
        end
    end

    ////////////////////////////////
    // Frame end latch and report trigger
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            boxes        <= '0;
            frame_cnt    <= '0;
            report_start <= 1'b0;
        end else begin
            report_start <= 1'b0;
            if (frame_end) begin
                boxes <= run_d;   // Includes the eop pixel itself
                if (frame_cnt == '0) begin
                    frame_cnt    <= CNT_W'(MSG_INTERVAL - 1);
                    report_start <= 1'b1;
                end else begin
                    frame_cnt <= frame_cnt - 1'b1;
                end
            end
        end
    end

endmodule

/* pixel_overlay.sv */
`timescale 1ns/1ps

module pixel_overlay import vision_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     overlay_en,
    input  box_set_t boxes,
    input  tagged_t  in_tag,
    input  logic     in_valid,
    output logic     in_ready,
    output beat_t    out_beat,
    output logic     out_valid,
    input  logic     out_ready
);

    logic [7:0] grey;
    colour_e    edge_hit;
    rgb_t       pix_new;
    rgb_t       p;

    assign in_ready = ~out_valid | out_ready;
    assign p        = in_tag.beat.pix;
    assign grey     = {1'b0, p.g[7:1]} + {2'b00, p.r[7:2]} + {2'b00, p.b[7:2]};

    always_comb begin
        edge_hit = CLR_NONE;
        // Walk down so red ends up with the highest priority
        for (int c = 4; c >= 1; c--) begin
            if (in_tag.x == boxes[c].left || in_tag.x == boxes[c].right ||
                in_tag.y == boxes[c].top  || in_tag.y == boxes[c].bottom) begin
                edge_hit = colour_e'(c);
            end
        end
        if (!overlay_en || !in_tag.video || in_tag.beat.sop) begin
            pix_new = p;
        end else if (edge_hit != CLR_NONE) begin
            pix_new = class_rgb(edge_hit);
        end else if (in_tag.colour != CLR_NONE) begin
            pix_new = class_rgb(in_tag.colour);
        end else begin
            pix_new = {grey, grey, grey};
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_beat <= {pix_new, in_tag.beat.sop, in_tag.beat.eop};
        end
    end

endmodule

/* msg_writer.sv */
`timescale 1ns/1ps

module msg_writer import vision_pkg::*, bus_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        report_start,
    input  box_set_t    boxes,
    input  logic [8:0]  fifo_count,
    output logic [31:0] wr_data,
    output logic        wr_en
);

    logic [3:0]  word_idx;   // Word being written or 0 when idle
    box_set_t    snap;
    box_t        cur;
    logic [11:0] sum_x;
    logic [11:0] sum_y;
    logic        room;

    assign room = (fifo_count <= 9'(FIFO_DEPTH - MSG_WORDS));

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            word_idx <= '0;
        end else if (word_idx != '0) begin
            word_idx <= (word_idx == 4'(MSG_WORDS)) ? '0 : word_idx + 1'b1;
        end else if (report_start && room) begin
            word_idx <= 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (report_start && word_idx == '0) begin
            snap <= boxes;
        end
    end

    ////////////////////////////////
    // Word format with two words per colour
    always_comb begin
        case (word_idx[3:1])
            3'd1:    cur = snap[CLR_RED];
            3'd2:    cur = snap[CLR_GREEN];
            3'd3:    cur = snap[CLR_BLUE];
            default: cur = snap[CLR_YELLOW];
        endcase
        sum_x = {1'b0, cur.left} + {1'b0, cur.right};
        sum_y = {1'b0, cur.top} + {1'b0, cur.bottom};
        if (word_idx == 4'd1) begin
            wr_data = MSG_START_ID;
        end else if (!word_idx[0]) begin
            wr_data = {5'b0, sum_x[11:1], 5'b0, sum_y[11:1]};   // Centre
        end else begin
            wr_data = {5'b0, cur.bottom - cur.top, 5'b0, cur.right - cur.left};   // Size
        end
    end

    assign wr_en = (word_idx != '0);

endmodule

/* msg_fifo.sv */
`timescale 1ns/1ps

module msg_fifo import bus_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        flush,
    input  logic [31:0] wr_data,
    input  logic        wr_en,
    input  logic        rd_en,
    output logic [31:0] rd_data,
    output logic [8:0]  count,
    output logic        empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [31:0]      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign empty   = (count == '0);
    assign do_wr   = wr_en & (count != 9'(FIFO_DEPTH));  // Full drops the word
    assign do_rd   = rd_en & ~empty;
    assign rd_data = mem[rd_ptr];   // Head always visible

    always_ff @(posedge clk) begin
        if (!reset_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + 9'(do_wr) - 9'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* axi_lite_regs.sv */
`timescale 1ns/1ps

module axi_lite_regs import bus_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp,
    input  logic [8:0]  fifo_count,
    input  logic        fifo_empty,
    input  logic [31:0] fifo_data,
    output logic        fifo_pop,
    output logic        fifo_flush,
    output logic        overlay_en
);

    logic        bvalid_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        wr_fire;
    logic        rd_fire;
    logic        status_wr;
    logic [7:0]  fill_sat;

    // Address and data taken together with one write in flight
    assign wr_fire   = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
    assign rd_fire   = axil_req.arvalid & ~rvalid_q;
    assign status_wr = wr_fire & (axil_req.awaddr == ADDR_STATUS) & axil_req.wstrb[0];
    assign fill_sat  = fifo_count[8] ? 8'hFF : fifo_count[7:0];

    assign fifo_flush = status_wr & axil_req.wdata[4];
    assign fifo_pop   = rd_fire & (axil_req.araddr == ADDR_MSG) & ~fifo_empty;

    assign axil_rsp.awready = wr_fire;
    assign axil_rsp.wready  = wr_fire;
    assign axil_rsp.bresp   = 2'b00;    // OKAY
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.arready = ~rvalid_q;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = 2'b00;
    assign axil_rsp.rvalid  = rvalid_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            overlay_en <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (status_wr) begin
                overlay_en <= axil_req.wdata[0];
            end
        end
    end

    ////////////////////////////////
    // Read data mux
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (axil_req.araddr)
                ADDR_STATUS: rdata_q <= {16'b0, fill_sat, 7'b0, overlay_en};
                ADDR_MSG:    rdata_q <= fifo_empty ? 32'b0 : fifo_data;
                ADDR_ID:     rdata_q <= LOCATOR_ID;
                default:     rdata_q <= 32'b0;
            endcase
        end
    end

endmodule

/* object_locator.sv */
`timescale 1ns/1ps

module object_locator import vision_pkg::*, bus_pkg::*; #(
    parameter int IMAGE_W      = 640,
    parameter int IMAGE_H      = 480,
    parameter int MSG_INTERVAL = 30
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [23:0] sink_data,
    input  logic        sink_sop,
    input  logic        sink_eop,
    input  logic        sink_valid,
    output logic        sink_ready,
    output logic [23:0] source_data,
    output logic        source_sop,
    output logic        source_eop,
    output logic        source_valid,
    input  logic        source_ready,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp
);

    beat_t       sink_beat;
    beat_t       in_beat;
    beat_t       ov_beat;
    beat_t       source_beat;
    tagged_t     tag;
    logic        in_valid, in_ready;
    logic        tag_valid, tag_ready;
    logic        ov_valid, ov_ready;
    box_set_t    boxes;
    logic        report_start;
    logic        overlay_en;
    logic [31:0] msg_data, fifo_data;
    logic        msg_wr, fifo_pop, fifo_flush, fifo_empty;
    logic [8:0]  fifo_count;

    assign sink_beat = {sink_data, sink_sop, sink_eop};
    assign {source_data, source_sop, source_eop} = source_beat;

    ////////////////////////////////
    // Video path
    stream_reg #(.payload_t(beat_t)) in_reg (
        .clk(clk), .reset_n(reset_n),
        .in_data(sink_beat), .in_valid(sink_valid), .in_ready(sink_ready),
        .out_data(in_beat), .out_valid(in_valid), .out_ready(in_ready)
    );

    pixel_tagger #(.IMAGE_W(IMAGE_W), .IMAGE_H(IMAGE_H)) tagger_i (
        .clk(clk), .reset_n(reset_n),
        .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
        .out_tag(tag), .out_valid(tag_valid), .out_ready(tag_ready)
    );

    box_tracker #(
        .IMAGE_W(IMAGE_W), .IMAGE_H(IMAGE_H), .MSG_INTERVAL(MSG_INTERVAL)
    ) tracker_i (
        .clk(clk), .reset_n(reset_n),
        .tag(tag), .tag_fire(tag_valid & tag_ready),  // Sampled on transfer only
        .boxes(boxes), .report_start(report_start)
    );

    pixel_overlay overlay_i (
        .clk(clk), .reset_n(reset_n), .overlay_en(overlay_en), .boxes(boxes),
        .in_tag(tag), .in_valid(tag_valid), .in_ready(tag_ready),
        .out_beat(ov_beat), .out_valid(ov_valid), .out_ready(ov_ready)
    );

    stream_reg #(.payload_t(beat_t)) out_reg (
        .clk(clk), .reset_n(reset_n),
        .in_data(ov_beat), .in_valid(ov_valid), .in_ready(ov_ready),
        .out_data(source_beat), .out_valid(source_valid), .out_ready(source_ready)
    );

    ////////////////////////////////
    // Report path and CPU port
    msg_writer writer_i (
        .clk(clk), .reset_n(reset_n), .report_start(report_start), .boxes(boxes),
        .fifo_count(fifo_count), .wr_data(msg_data), .wr_en(msg_wr)
    );

    msg_fifo fifo_i (
        .clk(clk), .reset_n(reset_n), .flush(fifo_flush),
        .wr_data(msg_data), .wr_en(msg_wr), .rd_en(fifo_pop),
        .rd_data(fifo_data), .count(fifo_count), .empty(fifo_empty)
    );

    axi_lite_regs regs_i (
        .clk(clk), .reset_n(reset_n), .axil_req(axil_req), .axil_rsp(axil_rsp),
        .fifo_count(fifo_count), .fifo_empty(fifo_empty), .fifo_data(fifo_data),
        .fifo_pop(fifo_pop), .fifo_flush(fifo_flush), .overlay_en(overlay_en)
    );

endmodule

/* object_locator_chk.sv */
`timescale 1ns/1ps

module object_locator_chk import bus_pkg::*; (
    input logic        clk,
    input logic        reset_n,
    input logic [23:0] source_data,
    input logic        source_sop,
    input logic        source_eop,
    input logic        source_valid,
    input logic        source_ready,
    input axil_req_t   axil_req,
    input axil_rsp_t   axil_rsp
);

    int fail_count = 0;   // Failed assertions so far

    ////////////////////////////////
    // Reset state
    reset_idle: assert property (@(posedge clk)
        !reset_n |=> !source_valid && !axil_rsp.bvalid && !axil_rsp.rvalid)
    else begin
        $error("source_valid, bvalid or rvalid high after a reset cycle");
        fail_count++;
    end

    ////////////////////////////////
    // Handshake stability
    source_hold: assert property (@(posedge clk) disable iff (!reset_n)
        source_valid && !source_ready
        |=> source_valid && $stable({source_data, source_sop, source_eop}))
    else begin
        $error("source beat changed or dropped while stalled");
        fail_count++;
    end

    bvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
        $error("bvalid fell before bready");
        fail_count++;
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else begin
        $error("rvalid fell or rdata changed before rready");
        fail_count++;
    end

endmodule

bind object_locator object_locator_chk chk_i (
    .clk(clk), .reset_n(reset_n),
    .source_data(source_data), .source_sop(source_sop), .source_eop(source_eop),
    .source_valid(source_valid), .source_ready(source_ready),
    .axil_req(axil_req), .axil_rsp(axil_rsp)
);

/* object_locator_tb.sv */
`timescale 1ns/1ps

module object_locator_tb import vision_pkg::*, bus_pkg::*; ();

    localparam int IMAGE_W = 8;
    localparam int IMAGE_H = 6;
    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        reset_n;
    logic [23:0] sink_data;
    logic        sink_sop, sink_eop, sink_valid, sink_ready;
    logic [23:0] source_data;
    logic        source_sop, source_eop, source_valid, source_ready;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;

    integer      seed = 82;
    int          errors = 0;
    int          timeouts = 0;
    string       test_name = "reset";
    logic        overlay_on = 1'b0;
    box_t        prev_box [1:4] = '{default: '0};   // Boxes latched by the last video frame
    logic [25:0] exp_q [$];                         // Expected {pixel, sop, eop}

    object_locator #(.IMAGE_W(IMAGE_W), .IMAGE_H(IMAGE_H), .MSG_INTERVAL(2)) dut_i (
        .clk(clk), .reset_n(reset_n),
        .sink_data(sink_data), .sink_sop(sink_sop), .sink_eop(sink_eop),
        .sink_valid(sink_valid), .sink_ready(sink_ready),
        .source_data(source_data), .source_sop(source_sop), .source_eop(source_eop),
        .source_valid(source_valid), .source_ready(source_ready),
        .axil_req(axil_req), .axil_rsp(axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        source_ready <= ($random(seed) % 4) != 0;   // Stall about one cycle in four
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timeout in %s while waiting for %s", test_name, what);
    endtask

    ////////////////////////////////
    // Scene model
    function automatic box_t rect_of(colour_e c, int f);
        box_t b;
        logic right_side;
        logic lower;
        right_side = (c == CLR_BLUE || c == CLR_YELLOW);
        lower      = (c == CLR_GREEN || c == CLR_YELLOW);
        if ((f / 2) % 2 == 0) begin   // Corner layout
            b.left   = right_side ? 11'd6 : 11'd0;
            b.top    = lower ? 11'd4 : 11'd0;
            b.bottom = lower ? 11'd5 : 11'd0;
        end else begin                // Centre layout
            b.left   = right_side ? 11'd4 : 11'd2;
            b.top    = lower ? 11'd3 : 11'd2;
            b.bottom = b.top;
        end
        b.right = b.left + 11'd1;
        return b;
    endfunction

    function automatic colour_e class_at(int x, int y, int f);
        box_t b;
        for (int c = 1; c <= 4; c++) begin
            b = rect_of(colour_e'(c), f);
            if (x >= b.left && x <= b.right && y >= b.top && y <= b.bottom) begin
                return colour_e'(c);
            end
        end
        return CLR_NONE;
    endfunction

    function automatic logic [7:0] shade(input logic [1:0] level);
        logic [31:0] v;
        v = $random(seed);
        case (level)
            2'd0:    return {2'b00, v[5:0]};          // Below the low threshold
            2'd1:    return 8'h40 + {1'b0, v[6:0]};   // Between thresholds
            default: return {2'b11, v[5:0]};
        endcase
    endfunction

    function automatic rgb_t make_pixel(colour_e c);
        logic [5:0] lv;
        rgb_t       p;
        case (c)
            CLR_RED:    lv = 6'b10_00_00;
            CLR_BLUE:   lv = 6'b00_00_10;
            CLR_GREEN:  lv = 6'b00_10_00;
            CLR_YELLOW: lv = 6'b10_10_00;
            default:    lv = 6'b01_01_01;
        endcase
        p.r = shade(lv[5:4]);
        p.g = shade(lv[3:2]);
        p.b = shade(lv[1:0]);
        return p;
    endfunction

    function automatic rgb_t display_colour(colour_e c);
        case (c)
            CLR_RED:   return 24'hFF0000;
            CLR_BLUE:  return 24'hCCFFFF;
            CLR_GREEN: return 24'h00FF00;
            default:   return 24'hFFFF00;
        endcase
    endfunction

    function automatic rgb_t expect_pixel(rgb_t p, colour_e c, int x, int y);
        logic [7:0] grey;
        if (!overlay_on) begin
            return p;
        end
        for (int k = 1; k <= 4; k++) begin   // Edges with red first
            if (x == prev_box[k].left || x == prev_box[k].right ||
                y == prev_box[k].top || y == prev_box[k].bottom) begin
                return display_colour(colour_e'(k));
            end
        end
        if (c != CLR_NONE) begin
            return display_colour(c);
        end
        grey = p.g / 2 + p.r / 4 + p.b / 4;
        return {grey, grey, grey};
    endfunction

    function automatic logic [31:0] report_word(int idx, int f);
        colour_e order [4] = '{CLR_RED, CLR_GREEN, CLR_BLUE, CLR_YELLOW};
        box_t    b;
        coord_t  cx;
        coord_t  cy;
        if (idx == 0) begin
            return 32'h0052_4242;   // "RBB"
        end
        b  = rect_of(order[(idx - 1) / 2], f);
        cx = (b.left + b.right) / 2;
        cy = (b.top + b.bottom) / 2;
        if (idx % 2 == 1) begin
            return {5'b0, cx, 5'b0, cy};
        end
        return {5'b0, coord_t'(b.bottom - b.top), 5'b0, coord_t'(b.right - b.left)};
    endfunction

    ////////////////////////////////
    // Stream driver and monitor
    task automatic send_beat(input rgb_t data, input rgb_t expected, input logic sop,
                             input logic eop);
        int n;
        exp_q.push_back({expected, sop, eop});
        sink_data  <= data;
        sink_sop   <= sop;
        sink_eop   <= eop;
        sink_valid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!sink_ready && n < TIMEOUT);
        if (!sink_ready) begin
            note_timeout("sink_ready");
        end
    endtask

    task automatic send_frame(input int f);
        colour_e c;
        rgb_t    p;
        send_beat(24'h123450, 24'h123450, 1'b1, 1'b0);   // Video descriptor
        for (int y = 0; y < IMAGE_H; y++) begin
            for (int x = 0; x < IMAGE_W; x++) begin
                c = class_at(x, y, f);
                p = make_pixel(c);
                send_beat(p, expect_pixel(p, c, x, y), 1'b0,
                          x == IMAGE_W - 1 && y == IMAGE_H - 1);
            end
        end
        sink_valid <= 1'b0;
        for (int k = 1; k <= 4; k++) begin
            prev_box[k] = rect_of(colour_e'(k), f);
        end
    endtask

    task automatic send_other_packet();
        rgb_t p;
        send_beat(24'h0A0B05, 24'h0A0B05, 1'b1, 1'b0);   // Non-zero nibble marks non-video
        for (int i = 0; i < 5; i++) begin
            p = make_pixel(colour_e'(i));
            send_beat(p, p, 1'b0, i == 4);
        end
        sink_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            note_timeout("the frame to leave source");
        end
        repeat (MSG_WORDS + 4) @(posedge clk);   // Report words follow eop at one per cycle
    endtask

    always @(posedge clk) begin
        if (reset_n && source_valid && source_ready) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Beat left source in %s with none expected", test_name);
            end
            if (exp_q.size() != 0) begin
                check_value(test_name, {6'b0, exp_q.pop_front()},
                            {6'b0, source_data, source_sop, source_eop});
            end
        end
    end

    ////////////////////////////////
    // AXI4-Lite master
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        int n;
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hF;
        axil_req.wvalid  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(axil_rsp.awready && axil_rsp.wready) && n < TIMEOUT);
        if (!(axil_rsp.awready && axil_rsp.wready)) begin
            note_timeout("awready and wready");
        end
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!axil_rsp.bvalid && n < TIMEOUT);
        if (!axil_rsp.bvalid) begin
            note_timeout("bvalid");
        end
        check_value(test_name, 32'h0, {30'b0, axil_rsp.bresp});   // OKAY
        axil_req.bready <= 1'b1;   // Response taken one cycle late
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        int n;
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!axil_rsp.arready && n < TIMEOUT);
        if (!axil_rsp.arready) begin
            note_timeout("arready");
        end
        axil_req.arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!axil_rsp.rvalid && n < TIMEOUT);
        if (!axil_rsp.rvalid) begin
            note_timeout("rvalid");
        end
        data = axil_rsp.rdata;
        check_value(test_name, 32'h0, {30'b0, axil_rsp.rresp});   // OKAY
        axil_req.rready <= 1'b1;   // Response taken one cycle late
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [31:0] expected);
        logic [31:0] d;
        axil_read(addr, d);
        check_value(test_name, expected, d);
    endtask

    task automatic read_report(input int f);
        for (int i = 0; i < MSG_WORDS; i++) begin
            read_check(ADDR_MSG, report_word(i, f));
        end
    endtask

    ////////////////////////////////
    // Test sequence
    initial begin
        reset_n      <= 1'b0;
        sink_data    <= '0;
        sink_sop     <= 1'b0;
        sink_eop     <= 1'b0;
        sink_valid   <= 1'b0;
        source_ready <= 1'b0;
        axil_req     <= '0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        check_value("reset", 32'b0100,
                    {28'b0, source_valid, sink_ready, axil_rsp.bvalid, axil_rsp.rvalid});

        test_name = "id";
        read_check(ADDR_ID, 32'h1234EEE2);

        test_name = "pass_through";
        send_frame(0);
        wait_drain();
        test_name = "report";
        read_check(ADDR_STATUS, 32'h0000_0900);
        read_report(0);
        read_check(ADDR_STATUS, 32'h0000_0000);

        test_name = "pass_through";
        send_other_packet();
        send_frame(1);
        wait_drain();
        test_name = "interval";
        read_check(ADDR_STATUS, 32'h0000_0000);   // Second frame of the interval

        test_name = "overlay";
        axil_write(ADDR_STATUS, 32'h1);
        overlay_on = 1'b1;
        send_frame(2);
        wait_drain();
        read_check(ADDR_STATUS, 32'h0000_0901);
        read_report(2);
        send_frame(3);
        wait_drain();
        test_name = "interval";
        read_check(ADDR_STATUS, 32'h0000_0001);

        test_name = "flush";
        send_frame(4);
        wait_drain();
        read_check(ADDR_STATUS, 32'h0000_0901);
        axil_write(ADDR_STATUS, 32'h11);
        read_check(ADDR_STATUS, 32'h0000_0001);
        read_check(ADDR_MSG, 32'h0);

        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, dut_i.chk_i.fail_count);
        if (errors + timeouts + dut_i.chk_i.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
vision_pkg.sv
bus_pkg.sv
stream_reg.sv
pixel_tagger.sv
box_tracker.sv
pixel_overlay.sv
msg_writer.sv
msg_fifo.sv
axi_lite_regs.sv
object_locator.sv
object_locator_chk.sv
object_locator_tb.sv
